// File: src/u1e_pkg.sv
// shared definitions for the host register side of the core
// bus widths, slave and register maps, packed bus structs
package u1e_pkg;

   ////////////////////////////////////////
   // widths and fixed values
   localparam int WB_AW         = 11;      // byte address of the host bus
   localparam int WB_DW         = 16;
   localparam int SLAVE_SEL_LSB = 7;       // adr[10:7] picks the slave
   localparam int SET_AW        = 8;
   localparam int SET_DW        = 32;

   localparam logic [7:0] COMPAT_NUM = 8'd6;

   // slave numbers, settings is double wide (8 and 9)
   localparam logic [3:0] SLAVE_MISC     = 4'd0;
   localparam logic [3:0] SLAVE_READBACK = 4'd7;
   localparam logic [3:0] SLAVE_SETTINGS = 4'd8;

   ////////////////////////////////////////
   // misc slave register offsets
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;    // out
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;    // in
   localparam logic [6:0] REG_TEST      = 7'd8;    // out
   localparam logic [6:0] REG_COMPAT    = 7'd16;   // in

   localparam logic [15:0] MISC_DEFAULT_RD = 16'hBEEF;

   // settings addresses
   localparam logic [7:0] SR_TIME64     = 8'd42;   // secs, ticks, load now
   localparam logic [7:0] SR_REG_TEST32 = 8'd60;

   // readback words, 32 bits each
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;

   ////////////////////////////////////////
   // bus structs
   typedef struct packed {
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic             we;
      logic             stb;
      logic             cyc;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
   } set_bus_t;

   // clock generator status pins
   typedef struct packed {
      logic status;
      logic ld;
      logic refmon;
   } cgen_status_t;

endpackage

// File: src/wb_slave_mux.sv
// address decode for the host bus
// gates each slave strobe and returns the selected response
`timescale 1ns/100ps

module wb_slave_mux
   (input  logic             wb_clk,      // used by bound checks
    input  logic             wb_rst,
    input  u1e_pkg::wb_req_t wb_req_i,
    output u1e_pkg::wb_rsp_t wb_rsp_o,
    output u1e_pkg::wb_req_t misc_req_o,
    output u1e_pkg::wb_req_t rb_req_o,
    output u1e_pkg::wb_req_t set_req_o,
    input  u1e_pkg::wb_rsp_t misc_rsp_i,
    input  u1e_pkg::wb_rsp_t rb_rsp_i,
    input  u1e_pkg::wb_rsp_t set_rsp_i);

   logic [3:0] slave_sel;
   logic       misc_hit, rb_hit, set_hit;

   assign slave_sel = wb_req_i.adr[u1e_pkg::WB_AW-1:u1e_pkg::SLAVE_SEL_LSB];

   assign misc_hit = (slave_sel == u1e_pkg::SLAVE_MISC);
   assign rb_hit   = (slave_sel == u1e_pkg::SLAVE_READBACK);
   // low decode bit ignored, settings spans 8 and 9
   assign set_hit  = ({slave_sel[3:1], 1'b0} == u1e_pkg::SLAVE_SETTINGS);

   ////////////////////////////////////////
   // request fan out
   always_comb
   begin
      misc_req_o     = wb_req_i;
      misc_req_o.stb = wb_req_i.stb & misc_hit;
      rb_req_o       = wb_req_i;
      rb_req_o.stb   = wb_req_i.stb & rb_hit;
      set_req_o      = wb_req_i;
      set_req_o.stb  = wb_req_i.stb & set_hit;
   end

   ////////////////////////////////////////
   // response merge
   always_comb
   begin
      if (misc_hit)
         wb_rsp_o = misc_rsp_i;
      else if (rb_hit)
         wb_rsp_o = rb_rsp_i;
      else if (set_hit)
         wb_rsp_o = set_rsp_i;
      else
         wb_rsp_o = '0;     // undecoded slaves never ack
   end

endmodule

// File: src/misc_regs.sv
// misc control slave: clock generator control and status,
// a scratch test register and the compat number
`timescale 1ns/100ps

module misc_regs
   (input  logic                  wb_clk,
    input  logic                  wb_rst,
    input  u1e_pkg::wb_req_t      req_i,
    output u1e_pkg::wb_rsp_t      rsp_o,
    input  u1e_pkg::cgen_status_t cgen_st_i,
    output logic                  cgen_sync_b_o,
    output logic                  cgen_ref_sel_o);

   logic [15:0] cgen_ctrl;
   logic [15:0] reg_test;
   logic [6:0]  reg_off;
   logic        wr_en;

   assign reg_off = req_i.adr[u1e_pkg::SLAVE_SEL_LSB-1:0];
   assign wr_en   = req_i.stb & req_i.cyc & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         cgen_ctrl <= 16'd3;     // sync_b and ref_sel both high
         reg_test  <= '0;
      end
      else if (wr_en)
      begin
         case (reg_off)
            u1e_pkg::REG_CGEN_CTRL : cgen_ctrl <= req_i.dat;
            u1e_pkg::REG_TEST      : reg_test  <= req_i.dat;
            default                : ;
         endcase
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = cgen_ctrl[1:0];

   // read side
   always_comb
   begin
      rsp_o.ack = req_i.stb & req_i.cyc;
      case (reg_off)
         u1e_pkg::REG_CGEN_CTRL : rsp_o.dat = cgen_ctrl;
         u1e_pkg::REG_CGEN_ST   : rsp_o.dat = {13'd0, cgen_st_i};
         u1e_pkg::REG_TEST      : rsp_o.dat = reg_test;
         u1e_pkg::REG_COMPAT    : rsp_o.dat = {8'd0, u1e_pkg::COMPAT_NUM};
         default                : rsp_o.dat = u1e_pkg::MISC_DEFAULT_RD;
      endcase
   end

endmodule

// File: src/settings_bus.sv
// settings bus, two 16-bit writes make one 32-bit setting strobe
`timescale 1ns/100ps

module settings_bus
   (input  logic              wb_clk,
    input  logic              wb_rst,
    input  u1e_pkg::wb_req_t  req_i,
    output u1e_pkg::wb_rsp_t  rsp_o,
    output u1e_pkg::set_bus_t set_o);

   logic [15:0]       low_half;     // first half-word, held for the high write
   logic              wr_lo, wr_hi;
   u1e_pkg::set_bus_t set_q;

   assign wr_lo = req_i.stb & req_i.cyc & req_i.we & ~req_i.adr[1];
   assign wr_hi = req_i.stb & req_i.cyc & req_i.we & req_i.adr[1];

   // strobe, one cycle per high half-word write
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_q.stb <= 1'b0;
      else
         set_q.stb <= wr_hi;
   end

   // payload
   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         low_half <= req_i.dat;
      if (wr_hi)
      begin
         set_q.data <= {req_i.dat, low_half};
         set_q.addr <= (u1e_pkg::SET_AW)'(req_i.adr[7:2]);   // 64 settings
      end
   end

   assign set_o = set_q;

   assign rsp_o.dat = '0;    // write only
   assign rsp_o.ack = req_i.stb & req_i.cyc;

endmodule

// File: src/time_regs.sv
// VITA time counter with PPS capture, loaded through settings
// also serves the 32-bit readback slave
`timescale 1ns/100ps

module time_regs
  #(parameter int unsigned ticks_per_sec = 64000000)
   (input  logic              wb_clk,
    input  logic              wb_rst,
    input  u1e_pkg::set_bus_t set_i,
    input  u1e_pkg::wb_req_t  req_i,
    output u1e_pkg::wb_rsp_t  rsp_o,
    input  logic              pps_i);

   logic [31:0] secs_hold, ticks_hold;   // staged by settings
   logic        load_now;
   logic [31:0] secs, ticks;             // running counter
   logic [63:0] vita_time, vita_time_pps;
   logic [1:0]  pps_sync;
   logic        pps_dly, pps_rise;
   logic [31:0] reg_test32;
   logic [3:0]  word_sel;
   logic [31:0] rb_word;

   ////////////////////////////////////////
   // settings capture
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs_hold  <= '0;
         ticks_hold <= '0;
         load_now   <= 1'b0;
      end
      else
      begin
         load_now <= set_i.stb & (set_i.addr == u1e_pkg::SR_TIME64 + 8'd2);
         if (set_i.stb && set_i.addr == u1e_pkg::SR_TIME64)
            secs_hold <= set_i.data;
         if (set_i.stb && set_i.addr == u1e_pkg::SR_TIME64 + 8'd1)
            ticks_hold <= set_i.data;
      end
   end

   // survives reset, shows the image is still loaded
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == u1e_pkg::SR_REG_TEST32)
         reg_test32 <= set_i.data;
   end

   ////////////////////////////////////////
   // time counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (load_now)
      begin
         secs  <= secs_hold;
         ticks <= ticks_hold;
      end
      else if (ticks == ticks_per_sec - 1)
      begin
         secs  <= secs + 32'd1;   // second rolls over
         ticks <= '0;
      end
      else
         ticks <= ticks + 32'd1;
   end

   assign vita_time = {secs, ticks};

   // pps sync and capture
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync      <= '0;
         pps_dly       <= 1'b0;
         vita_time_pps <= '0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_dly  <= pps_sync[1];
         if (pps_rise)
            vita_time_pps <= vita_time;
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_dly;

   ////////////////////////////////////////
   // readback, adr[5:2] picks the word, adr[1] the half
   assign word_sel = req_i.adr[5:2];

   always_comb
   begin
      case (word_sel)
         u1e_pkg::RB_TIME_HI : rb_word = vita_time[63:32];
         u1e_pkg::RB_TIME_LO : rb_word = vita_time[31:0];
         u1e_pkg::RB_PPS_HI  : rb_word = vita_time_pps[63:32];
         u1e_pkg::RB_PPS_LO  : rb_word = vita_time_pps[31:0];
         u1e_pkg::RB_TEST32  : rb_word = reg_test32;
         default             : rb_word = '0;
      endcase
   end

   assign rsp_o.dat = req_i.adr[1] ? rb_word[31:16] : rb_word[15:0];
   assign rsp_o.ack = req_i.stb & req_i.cyc;

endmodule

// File: src/u1e_core.sv
// host register core: misc control, settings bus, VITA time and readback
`timescale 1ns/100ps

module u1e_core
  #(parameter int unsigned ticks_per_sec = 64000000)
   (input  logic                  wb_clk,
    input  logic                  wb_rst,
    input  u1e_pkg::wb_req_t      wb_req_i,
    output u1e_pkg::wb_rsp_t      wb_rsp_o,
    input  u1e_pkg::cgen_status_t cgen_st_i,
    output logic                  cgen_sync_b_o,
    output logic                  cgen_ref_sel_o,
    input  logic                  pps_i);

   u1e_pkg::wb_req_t  misc_req, rb_req, set_req;   // per-slave copies
   u1e_pkg::wb_rsp_t  misc_rsp, rb_rsp, set_rsp;
   u1e_pkg::set_bus_t set_bus;

   ////////////////////////////////////////
   // single master intercon
   wb_slave_mux wb_slave_mux_inst
     (.wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .misc_req_o (misc_req),
      .rb_req_o   (rb_req),
      .set_req_o  (set_req),
      .misc_rsp_i (misc_rsp),
      .rb_rsp_i   (rb_rsp),
      .set_rsp_i  (set_rsp));

   // slave 0
   misc_regs misc_regs_inst
     (.wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .req_i          (misc_req),
      .rsp_o          (misc_rsp),
      .cgen_st_i      (cgen_st_i),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o));

   // slaves 8 and 9, feeds the time block
   settings_bus settings_bus_inst
     (.wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus));

   ////////////////////////////////////////
   // VITA time and readback, slave 7
   time_regs
     #(.ticks_per_sec(ticks_per_sec))
   time_regs_inst
     (.wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .set_i  (set_bus),
      .req_i  (rb_req),
      .rsp_o  (rb_rsp),
      .pps_i  (pps_i));

endmodule

// File: test/u1e_core_assertions.sv
// bus protocol checks on the slave mux
// one slave strobe at a time, acks only for live requests
`timescale 1ns/100ps

module u1e_core_assertions
   (input logic             wb_clk,
    input logic             wb_rst,
    input u1e_pkg::wb_req_t req_i,
    input u1e_pkg::wb_rsp_t rsp_i,
    input u1e_pkg::wb_req_t misc_req_i,
    input u1e_pkg::wb_req_t rb_req_i,
    input u1e_pkg::wb_req_t set_req_i);

   one_slave_stb : assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_req_i.stb, rb_req_i.stb, set_req_i.stb}))
      else $error("more than one slave strobe is high");

   ack_needs_req : assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_i.ack |-> (req_i.stb && req_i.cyc))
      else $error("ack is high without stb and cyc");

   ack_known : assert property (@(posedge wb_clk) disable iff (wb_rst)
      !$isunknown(rsp_i.ack))
      else $error("response ack is unknown");

endmodule

bind wb_slave_mux u1e_core_assertions u1e_core_assertions_inst
   (.wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(wb_req_i), .rsp_i(wb_rsp_o),
    .misc_req_i(misc_req_o), .rb_req_i(rb_req_o), .set_req_i(set_req_o));

// File: test/u1e_core_tb.sv
// testbench for the host register core
// directed tests over the wishbone bus, settings path, time and pps
`timescale 1ns/100ps

module u1e_core_tb;

   localparam int WATCHDOG_CYCLES = 3000;   // tests take about 320 cycles

   logic                  wb_clk, wb_rst, pps, cgen_sync_b, cgen_ref_sel;
   u1e_pkg::wb_req_t      wb_req;
   u1e_pkg::wb_rsp_t      wb_rsp;
   u1e_pkg::cgen_status_t cgen_st;
   logic [31:0]           rng_state;
   int unsigned           cycle_count;

   u1e_core #(.ticks_per_sec(100)) u1e_core_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .cgen_st_i(cgen_st), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .pps_i(pps));

   initial
   begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) cycle_count <= cycle_count + 1;

   ////////////////////////////////////////
   // helpers
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
         fail_run($sformatf("CHECK FAILED %s expected %h actual %h",
                            test_name, expected, actual));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] value);
      rng_state = xorshift32(rng_state);
      value     = rng_state;
   endtask

   function automatic logic [10:0] misc_adr(input logic [6:0] off);
      return {u1e_pkg::SLAVE_MISC, off};
   endfunction

   function automatic logic [10:0] rb_adr(input logic [3:0] word, input logic hi);
      return {u1e_pkg::SLAVE_READBACK, 1'b0, word, hi, 1'b0};
   endfunction

   // bit 7 of the address doubles as the slave lsb, so settings span slaves 8 and 9
   function automatic logic [10:0] set_adr(input logic [7:0] sa, input logic hi);
      return {u1e_pkg::SLAVE_SETTINGS, 7'd0} | {3'd0, sa[5:0], hi, 1'b0};
   endfunction

   task automatic apply_reset();
      @(posedge wb_clk);
      wb_rst <= 1'b1;
      repeat (8) @(posedge wb_clk);
      wb_rst <= 1'b0;
   endtask

   ////////////////////////////////////////
   // bus cycles, ack sampled mid-cycle
   task automatic bus_cycle(input logic [10:0] adr, input logic we, input logic [15:0] wdat,
                            output logic [15:0] rdat);
      logic got_ack;
      got_ack = 1'b0;
      @(posedge wb_clk);
      wb_req.adr <= adr;
      wb_req.dat <= wdat;
      wb_req.we  <= we;
      wb_req.stb <= 1'b1;
      wb_req.cyc <= 1'b1;
      for (int i = 0; i < 4 && !got_ack; i++)
      begin
         @(negedge wb_clk);
         got_ack = wb_rsp.ack;
         rdat    = wb_rsp.dat;
         if (!got_ack)
            @(posedge wb_clk);
      end
      if (!got_ack)
         fail_run($sformatf("no ack within 4 cycles for address %h", adr));
      @(posedge wb_clk);           // slave captures the write on this edge
      wb_req.stb <= 1'b0;
      wb_req.cyc <= 1'b0;
      wb_req.we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_cycle(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input logic [10:0] adr, output logic [15:0] dat);
      bus_cycle(adr, 1'b0, 16'd0, dat);
   endtask

   task automatic set_write32(input logic [7:0] sa, input logic [31:0] data);
      wb_write(set_adr(sa, 1'b0), data[15:0]);
      wb_write(set_adr(sa, 1'b1), data[31:16]);   // high half fires the strobe
   endtask

   task automatic rb_read32(input logic [3:0] word, output logic [31:0] value);
      logic [15:0] lo, hi;
      wb_read(rb_adr(word, 1'b0), lo);
      wb_read(rb_adr(word, 1'b1), hi);
      value = {hi, lo};
   endtask

   task automatic load_time(input logic [31:0] secs);
      set_write32(u1e_pkg::SR_TIME64, secs);
      set_write32(u1e_pkg::SR_TIME64 + 8'd1, 32'd0);
      set_write32(u1e_pkg::SR_TIME64 + 8'd2, 32'd0);
   endtask

   ////////////////////////////////////////
   // directed tests
   task automatic reset_defaults_test();
      logic [15:0] rd;
      check_value("reset_defaults sync_b", 32'd1, {31'd0, cgen_sync_b});
      check_value("reset_defaults ref_sel", 32'd1, {31'd0, cgen_ref_sel});
      wb_read(misc_adr(u1e_pkg::REG_CGEN_CTRL), rd);
      check_value("reset_defaults cgen_ctrl", 32'd3, {16'd0, rd});
      wb_read(misc_adr(u1e_pkg::REG_COMPAT), rd);
      check_value("reset_defaults compat", 32'd6, {16'd0, rd});
      wb_read(misc_adr(7'd12), rd);
      check_value("reset_defaults unlisted", 32'h0000_beef, {16'd0, rd});
   endtask

   task automatic misc_rw_test();
      logic [31:0] ctrl_val, test_val, st_val;
      logic [15:0] ctrl_pat, rd;
      logic [2:0]  st_pat;
      next_rand(ctrl_val);
      next_rand(test_val);
      next_rand(st_val);
      // flip each low bit in turn so both outputs see both levels
      for (int i = 0; i < 3; i++)
      begin
         ctrl_pat = ctrl_val[15:0] ^ 16'(i);
         wb_write(misc_adr(u1e_pkg::REG_CGEN_CTRL), ctrl_pat);
         @(negedge wb_clk);
         check_value("misc_rw sync_b", {31'd0, ctrl_pat[1]}, {31'd0, cgen_sync_b});
         check_value("misc_rw ref_sel", {31'd0, ctrl_pat[0]}, {31'd0, cgen_ref_sel});
         wb_read(misc_adr(u1e_pkg::REG_CGEN_CTRL), rd);
         check_value("misc_rw cgen_ctrl", {16'd0, ctrl_pat}, {16'd0, rd});
      end
      wb_write(misc_adr(u1e_pkg::REG_TEST), test_val[15:0]);
      wb_read(misc_adr(u1e_pkg::REG_TEST), rd);
      check_value("misc_rw test_reg", {16'd0, test_val[15:0]}, {16'd0, rd});
      for (int i = 0; i < 3; i++)
      begin
         st_pat = st_val[2:0] ^ (3'b001 << i);   // one status bit flipped per pass
         @(posedge wb_clk);
         cgen_st <= st_pat;
         wb_read(misc_adr(u1e_pkg::REG_CGEN_ST), rd);
         check_value("misc_rw cgen_status", {29'd0, st_pat}, {16'd0, rd});
      end
   endtask

   task automatic settings_path_test();
      logic [31:0] word, rd;
      next_rand(word);
      set_write32(u1e_pkg::SR_REG_TEST32, word);
      rb_read32(u1e_pkg::RB_TEST32, rd);
      check_value("settings_path test32", word, rd);
      apply_reset();
      rb_read32(u1e_pkg::RB_TEST32, rd);
      check_value("settings_path after reset", word, rd);
   endtask

   task automatic time_load_test();
      logic [31:0] secs, rd;
      int unsigned start;
      next_rand(secs);
      load_time(secs);
      start = cycle_count;
      rb_read32(u1e_pkg::RB_TIME_HI, rd);
      while (rd !== secs && cycle_count - start < 50)
         rb_read32(u1e_pkg::RB_TIME_HI, rd);
      check_value("time_load secs", secs, rd);
      repeat (150) @(posedge wb_clk);
      rb_read32(u1e_pkg::RB_TIME_HI, rd);
      check_value("time_load next second", secs + 32'd1, rd);
   endtask

   task automatic pps_capture_test();
      logic [31:0] secs, rd;
      next_rand(secs);
      load_time(secs);
      @(posedge wb_clk);
      pps <= 1'b1;
      repeat (10) @(posedge wb_clk);
      rb_read32(u1e_pkg::RB_PPS_HI, rd);
      check_value("pps_capture secs", secs, rd);
      pps <= 1'b0;
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog
   initial
   begin
      wb_rst      = 1'b1;
      wb_req      = '0;
      cgen_st     = '0;
      pps         = 1'b0;
      cycle_count = 0;
      rng_state   = 32'hdc46_3251;
      apply_reset();
      reset_defaults_test();
      misc_rw_test();
      settings_path_test();
      time_load_test();
      pps_capture_test();
      $display("All tests passed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
      fail_run("watchdog expired before the tests finished");
   end

endmodule

// File: u1e_core.f
src/u1e_pkg.sv
src/wb_slave_mux.sv
src/misc_regs.sv
src/settings_bus.sv
src/time_regs.sv
src/u1e_core.sv
test/u1e_core_assertions.sv
test/u1e_core_tb.sv
